// ==== common/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data and address width
`define MIPS_XLEN 32

// first fetch after reset, program image sits here
`define MIPS_RESET_PC 32'h0000_4000

// general purpose registers, r0 hardwired
`define MIPS_NREGS 32

`endif

// ==== common/mips_pkg.sv ====
package mips_pkg;

	// primary opcode, instruction bits 31:26
	typedef enum logic [5:0] {
		opc_rtype = 6'h00, // operation comes from funct
		opc_j     = 6'h02,
		opc_beq   = 6'h04,
		opc_addi  = 6'h08,
		opc_lw    = 6'h23,
		opc_sw    = 6'h2b
	} opcode_t;

	// r-type function field, bits 5:0
	typedef enum logic [5:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a  // signed compare
	} funct_t;

	// operation class from controller to alu
	typedef enum logic [1:0] {
		aluop_add   = 2'd0, // pc+4, addresses, addi
		aluop_sub   = 2'd1, // beq compare
		aluop_funct = 2'd2  // decode funct field
	} alu_op_t;

	// second alu operand
	typedef enum logic [1:0] {
		srcb_reg    = 2'd0, // b register
		srcb_four   = 2'd1, // pc increment
		srcb_imm    = 2'd2, // sign extended immediate
		srcb_imm_sh = 2'd3  // immediate << 2, branch offset
	} alu_src_b_t;

	// next pc source
	typedef enum logic [1:0] {
		pcsrc_alu     = 2'd0, // alu result, used in fetch
		pcsrc_alu_out = 2'd1, // branch target computed in decode
		pcsrc_jump    = 2'd2  // pseudo-direct jump target
	} pc_src_t;

	// multicycle controller states
	typedef enum logic [3:0] {
		st_fetch, st_decode,
		st_mem_addr, st_mem_read, st_mem_wb, st_mem_write,
		st_rtype_exec, st_rtype_wb,
		st_addi_exec, st_addi_wb,
		st_branch, st_jump
	} state_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps

`include "mips_cfg.svh"

module alu (
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	input  mips_pkg::alu_op_t     alu_op,
	input  mips_pkg::funct_t      funct,  // only looked at for r-type
	output logic [`MIPS_XLEN-1:0] result,
	output logic                  zero
);

	import mips_pkg::*;

	// resolved operation
	typedef enum logic [2:0] {
		do_add,
		do_sub,
		do_and,
		do_or,
		do_slt
	} alu_fn_t;

	alu_fn_t fn;

	// class plus funct field to operation
	always_comb begin
		case (alu_op)
			aluop_add: fn = do_add;
			aluop_sub: fn = do_sub;
			aluop_funct: begin
				case (funct)
					fn_add:  fn = do_add;
					fn_sub:  fn = do_sub;
					fn_and:  fn = do_and;
					fn_or:   fn = do_or;
					fn_slt:  fn = do_slt;
					default: fn = do_add; // unsupported funct
				endcase
			end
			default: fn = do_add;
		endcase
	end

	always_comb begin
		case (fn)
			do_add:  result = a + b;
			do_sub:  result = a - b;
			do_and:  result = a & b;
			do_or:   result = a | b;
			do_slt:  result = ($signed(a) < $signed(b)) ? `MIPS_XLEN'd1 : '0;
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0); // beq uses this after sub

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

`include "mips_cfg.svh"

module register_file (
	input  logic                            clk,
	input  logic                            rstb,
	input  logic [$clog2(`MIPS_NREGS)-1:0]  ra1,  // rs
	input  logic [$clog2(`MIPS_NREGS)-1:0]  ra2,  // rt
	input  logic [$clog2(`MIPS_NREGS)-1:0]  wa,
	input  logic [`MIPS_XLEN-1:0]           wd,
	input  logic                            we,
	output logic [`MIPS_XLEN-1:0]           rd1,
	output logic [`MIPS_XLEN-1:0]           rd2
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	// write at the edge, r0 never written so it stays zero
	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// combinational reads
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input  logic                 clk,
	input  logic                 rstb,
	input  mips_pkg::opcode_t    opcode, // from instruction register
	output logic                 pc_write,
	output logic                 pc_write_cond,
	output logic                 i_or_d,
	output logic                 mem_write,
	output logic                 ir_write,
	output logic                 reg_write,
	output logic                 mem_to_reg,
	output logic                 reg_dst,
	output logic                 alu_src_a,
	output mips_pkg::alu_src_b_t alu_src_b,
	output mips_pkg::alu_op_t    alu_op,
	output mips_pkg::pc_src_t    pc_src
);

	import mips_pkg::*;

	state_t state;
	state_t state_nxt;

	always_ff @(posedge clk) begin
		if (!rstb) state <= st_fetch;
		else       state <= state_nxt;
	end

	// next state, one cycle per state
	always_comb begin
		state_nxt = st_fetch;
		case (state)
			st_fetch: state_nxt = st_decode;
			st_decode: begin
				case (opcode)
					opc_lw, opc_sw: state_nxt = st_mem_addr;
					opc_rtype:      state_nxt = st_rtype_exec;
					opc_addi:       state_nxt = st_addi_exec;
					opc_beq:        state_nxt = st_branch;
					opc_j:          state_nxt = st_jump;
					default:        state_nxt = st_fetch; // unsupported, skip it
				endcase
			end
			st_mem_addr:   state_nxt = (opcode == opc_lw) ? st_mem_read : st_mem_write;
			st_mem_read:   state_nxt = st_mem_wb;
			st_rtype_exec: state_nxt = st_rtype_wb;
			st_addi_exec:  state_nxt = st_addi_wb;
			default:       state_nxt = st_fetch; // wb, store, branch, jump end here
		endcase
	end

	// moore outputs
	always_comb begin
		pc_write      = 1'b0;
		pc_write_cond = 1'b0;
		i_or_d        = 1'b0;
		mem_write     = 1'b0;
		ir_write      = 1'b0;
		reg_write     = 1'b0;
		mem_to_reg    = 1'b0;
		reg_dst       = 1'b0;
		alu_src_a     = 1'b0;
		alu_src_b     = srcb_reg;
		alu_op        = aluop_add;
		pc_src        = pcsrc_alu;
		case (state)
			st_fetch: begin
				ir_write  = 1'b1;
				alu_src_b = srcb_four; // pc + 4
				pc_write  = 1'b1;
			end
			st_decode: begin
				alu_src_b = srcb_imm_sh; // branch target into alu_out, used if beq
			end
			st_mem_addr: begin
				alu_src_a = 1'b1;
				alu_src_b = srcb_imm; // base + offset
			end
			st_mem_read: begin
				i_or_d = 1'b1;
			end
			st_mem_wb: begin
				reg_write  = 1'b1;
				mem_to_reg = 1'b1; // rt <= mdr
			end
			st_mem_write: begin
				i_or_d    = 1'b1;
				mem_write = 1'b1;
			end
			st_rtype_exec: begin
				alu_src_a = 1'b1;
				alu_op    = aluop_funct;
			end
			st_rtype_wb: begin
				reg_write = 1'b1;
				reg_dst   = 1'b1; // rd
			end
			st_addi_exec: begin
				alu_src_a = 1'b1;
				alu_src_b = srcb_imm;
			end
			st_addi_wb: begin
				reg_write = 1'b1; // rt <= alu_out
			end
			st_branch: begin
				alu_src_a     = 1'b1;
				alu_op        = aluop_sub; // rs - rt, zero if equal
				pc_write_cond = 1'b1;
				pc_src        = pcsrc_alu_out;
			end
			st_jump: begin
				pc_write = 1'b1;
				pc_src   = pcsrc_jump;
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/mips.sv ====
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips (
	input  logic                  clk,
	input  logic                  rstb,
	input  logic [`MIPS_XLEN-1:0] mem_rd_data, // instruction or load data, same cycle
	output logic [`MIPS_XLEN-1:0] mem_addr,
	output logic [`MIPS_XLEN-1:0] mem_wr_data,
	output logic                  mem_wr_ena,
	output logic [`MIPS_XLEN-1:0] pc
);

	import mips_pkg::*;

	// controller strobes
	logic       pc_write;
	logic       pc_write_cond;
	logic       i_or_d;
	logic       mem_write;
	logic       ir_write;
	logic       reg_write;
	logic       mem_to_reg;
	logic       reg_dst;
	logic       alu_src_a;
	alu_src_b_t alu_src_b;
	alu_op_t    alu_op;
	pc_src_t    pc_src;

	// datapath state, no reset on payload
	logic [`MIPS_XLEN-1:0] ir;      // instruction register
	logic [`MIPS_XLEN-1:0] mdr;     // memory data register
	logic [`MIPS_XLEN-1:0] reg_a;   // rs operand
	logic [`MIPS_XLEN-1:0] reg_b;   // rt operand, also store data
	logic [`MIPS_XLEN-1:0] alu_out; // registered alu result

	logic [`MIPS_XLEN-1:0] src_a;
	logic [`MIPS_XLEN-1:0] src_b;
	logic [`MIPS_XLEN-1:0] alu_result;
	logic                  zero;
	logic [`MIPS_XLEN-1:0] imm_ext;
	logic [`MIPS_XLEN-1:0] jump_target;
	logic [`MIPS_XLEN-1:0] pc_next;
	logic                  pc_en;
	logic [`MIPS_XLEN-1:0] rd1;
	logic [`MIPS_XLEN-1:0] rd2;
	logic [4:0]            wa;      // rt or rd
	logic [`MIPS_XLEN-1:0] wd;

	// memory side
	assign mem_addr    = i_or_d ? alu_out : pc; // data access after fetch
	assign mem_wr_data = reg_b;
	assign mem_wr_ena  = mem_write;

	// immediate and jump target
	assign imm_ext     = {{(`MIPS_XLEN-16){ir[15]}}, ir[15:0]};
	assign jump_target = {pc[31:28], ir[25:0], 2'b00}; // pc already +4 here

	// alu operand selection
	assign src_a = alu_src_a ? reg_a : pc;

	always_comb begin
		case (alu_src_b)
			srcb_reg:    src_b = reg_b;
			srcb_four:   src_b = `MIPS_XLEN'd4;
			srcb_imm:    src_b = imm_ext;
			srcb_imm_sh: src_b = {imm_ext[`MIPS_XLEN-3:0], 2'b00}; // word offset
			default:     src_b = reg_b;
		endcase
	end

	// write-back selection
	assign wa = reg_dst ? ir[15:11] : ir[20:16]; // rd for r-type, rt otherwise
	assign wd = mem_to_reg ? mdr : alu_out;

	// next pc
	always_comb begin
		case (pc_src)
			pcsrc_alu:     pc_next = alu_result;
			pcsrc_alu_out: pc_next = alu_out;
			pcsrc_jump:    pc_next = jump_target;
			default:       pc_next = alu_result;
		endcase
	end

	assign pc_en = pc_write | (pc_write_cond & zero); // taken beq only

	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc <= `MIPS_RESET_PC;
		end else if (pc_en) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_write) ir <= mem_rd_data; // only in fetch
		mdr     <= mem_rd_data; // captured at end of mem_read
		reg_a   <= rd1;
		reg_b   <= rd2;
		alu_out <= alu_result;
	end

	control_unit i_control_unit (
		.clk           (clk),
		.rstb          (rstb),
		.opcode        (opcode_t'(ir[31:26])),
		.pc_write      (pc_write),
		.pc_write_cond (pc_write_cond),
		.i_or_d        (i_or_d),
		.mem_write     (mem_write),
		.ir_write      (ir_write),
		.reg_write     (reg_write),
		.mem_to_reg    (mem_to_reg),
		.reg_dst       (reg_dst),
		.alu_src_a     (alu_src_a),
		.alu_src_b     (alu_src_b),
		.alu_op        (alu_op),
		.pc_src        (pc_src)
	);

	alu i_alu (
		.a      (src_a),
		.b      (src_b),
		.alu_op (alu_op),
		.funct  (funct_t'(ir[5:0])), // unknown codes fall back to add
		.result (alu_result),
		.zero   (zero)
	);

	register_file i_register_file (
		.clk  (clk),
		.rstb (rstb),
		.ra1  (ir[25:21]), // rs
		.ra2  (ir[20:16]), // rt
		.wa   (wa),
		.wd   (wd),
		.we   (reg_write),
		.rd1  (rd1),
		.rd2  (rd2)
	);

endmodule

// ==== sim/mips_props.sv ====
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_props (
	input logic                  clk,
	input logic                  rstb,
	input logic [`MIPS_XLEN-1:0] pc,
	input logic [`MIPS_XLEN-1:0] ir,
	input logic                  ir_write,      // high only in fetch
	input logic                  mem_wr_ena,
	input logic [`MIPS_XLEN-1:0] mem_wr_data
);

	import mips_pkg::*;

	localparam int reg_bits = $clog2(`MIPS_NREGS);

	int unsigned err_count = 0; // polled by the testbench

	logic [5:0] opc;
	logic       rt_is_r0;
	logic       fetch;

	assign opc      = ir[31:26]; // valid from decode on
	assign rt_is_r0 = (ir[16 +: reg_bits] == '0);
	assign fetch    = rstb && ir_write; // controller also sits in fetch while in reset

	// fetch steps pc by one word
	a_fetch_inc: assert property (@(posedge clk) disable iff (!rstb)
		fetch |=> pc == $past(pc) + 32'd4)
		else begin
			$error("pc did not advance by 4 after fetch");
			err_count++;
		end

	// pc holds after fetch unless a beq or j is running
	a_pc_hold: assert property (@(posedge clk) disable iff (!rstb)
		(rstb && !ir_write && opc != opc_beq && opc != opc_j) |=> $stable(pc))
		else begin
			$error("pc changed outside fetch, branch or jump");
			err_count++;
		end

	// fetch to fetch latency per class
	a_lat3: assert property (@(posedge clk) disable iff (!rstb)
		(fetch ##1 (opc == opc_beq || opc == opc_j)) |-> !ir_write [*2] ##1 ir_write)
		else begin
			$error("beq or j did not take 3 cycles");
			err_count++;
		end

	a_lat4: assert property (@(posedge clk) disable iff (!rstb)
		(fetch ##1 (opc == opc_sw || opc == opc_rtype || opc == opc_addi))
		|-> !ir_write [*3] ##1 ir_write)
		else begin
			$error("sw, r-type or addi did not take 4 cycles");
			err_count++;
		end

	a_lat5: assert property (@(posedge clk) disable iff (!rstb)
		(fetch ##1 opc == opc_lw) |-> !ir_write [*4] ##1 ir_write)
		else begin
			$error("lw did not take 5 cycles");
			err_count++;
		end

	// one write strobe per store in its 4th cycle
	a_sw_strobe: assert property (@(posedge clk) disable iff (!rstb)
		(fetch ##1 opc == opc_sw) |-> !mem_wr_ena [*2] ##1 mem_wr_ena ##1 !mem_wr_ena)
		else begin
			$error("store write strobe not exactly one cycle");
			err_count++;
		end

	a_wr_only_sw: assert property (@(posedge clk) disable iff (!rstb)
		mem_wr_ena |-> opc == opc_sw)
		else begin
			$error("memory write outside a store");
			err_count++;
		end

	// r0 stays zero even after a write attempt
	a_r0_store: assert property (@(posedge clk) disable iff (!rstb)
		(mem_wr_ena && rt_is_r0) |-> mem_wr_data == '0)
		else begin
			$error("store of r0 wrote a nonzero value");
			err_count++;
		end

endmodule

bind mips mips_props i_mips_props (
	.clk           (clk),
	.rstb          (rstb),
	.pc            (pc),
	.ir            (ir),
	.ir_write      (ir_write),
	.mem_wr_ena    (mem_wr_ena),
	.mem_wr_data   (mem_wr_data)
);

// ==== sim/mips_tb.sv ====
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_tb;

	import mips_pkg::*;

	localparam logic [31:0] data_base     = 32'h0000_4400; // the two operands
	localparam logic [31:0] store_base    = 32'h0000_4500; // result words
	localparam logic [31:0] sentinel_addr = 32'h0000_4600; // wrong path only
	localparam logic [15:0] neg_imm       = 16'hfb2e;      // -1234
	localparam logic [15:0] marker        = 16'h0055;      // fall-through proof
	localparam int          n_stores      = 8;
	localparam int          reset_cycles  = 16;
	// 2 lw, 16 four-cycle instructions, 2 beq and the first j
	localparam int          run_cycles    = 2*5 + 16*4 + 3*3;

	logic                  clk;
	logic                  rstb;
	logic [`MIPS_XLEN-1:0] mem_rd_data;
	logic [`MIPS_XLEN-1:0] mem_addr;
	logic [`MIPS_XLEN-1:0] mem_wr_data;
	logic                  mem_wr_ena;
	logic [`MIPS_XLEN-1:0] pc;

	logic [31:0] mem [0:8191];              // 32 KB indexed by byte address bits 14:2
	logic [31:0] lfsr_state = 32'h792f_2b7e;
	logic [31:0] prog_ptr;
	logic [31:0] done_addr;                 // final self-loop
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] exp_addr [n_stores];
	logic [31:0] exp_data [n_stores];
	int          store_idx = 0;

	mips i_mips (
		.clk         (clk),
		.rstb        (rstb),
		.mem_rd_data (mem_rd_data),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena),
		.pc          (pc)
	);

	assign mem_rd_data = mem[mem_addr[14:2]]; // same-cycle read

	always @(posedge clk) begin
		if (mem_wr_ena === 1'b1) mem[mem_addr[14:2]] <= mem_wr_data;
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w          = {w[30:0], lfsr_state[0]}; // one step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
		return w;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
		return 32'hdead_0000 ^ byte_addr; // decodes as an unknown opcode
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input funct_t fn);
		return {opc_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_t op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] target);
		return {opc_j, target[27:2]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic emit(input logic [31:0] w);
		mem[prog_ptr[14:2]] = w;
		prog_ptr            = prog_ptr + 32'd4;
	endtask

	task automatic load_image();
		for (int i = 0; i < 8192; i++) mem[i] = fill_word(i * 4);
		op_a                    = rand_word();
		op_b                    = rand_word();
		mem[data_base[14:2]]     = op_a;
		mem[data_base[14:2] + 1] = op_b;
		prog_ptr = `MIPS_RESET_PC;
		emit(enc_i(opc_lw, 5'd0, 5'd1, data_base[15:0]));
		emit(enc_i(opc_lw, 5'd0, 5'd2, data_base[15:0] + 16'd4));
		emit(enc_r(5'd1, 5'd2, 5'd3, fn_add));
		emit(enc_i(opc_sw, 5'd0, 5'd3, store_base[15:0]));
		emit(enc_r(5'd1, 5'd2, 5'd4, fn_sub));
		emit(enc_i(opc_sw, 5'd0, 5'd4, store_base[15:0] + 16'd4));
		emit(enc_r(5'd1, 5'd2, 5'd5, fn_and));
		emit(enc_i(opc_sw, 5'd0, 5'd5, store_base[15:0] + 16'd8));
		emit(enc_r(5'd1, 5'd2, 5'd6, fn_or));
		emit(enc_i(opc_sw, 5'd0, 5'd6, store_base[15:0] + 16'd12));
		emit(enc_r(5'd1, 5'd2, 5'd7, fn_slt));
		emit(enc_i(opc_sw, 5'd0, 5'd7, store_base[15:0] + 16'd16));
		emit(enc_i(opc_addi, 5'd1, 5'd8, neg_imm));  // negative immediate
		emit(enc_i(opc_sw, 5'd0, 5'd8, store_base[15:0] + 16'd20));
		emit(enc_i(opc_addi, 5'd1, 5'd0, 16'd5));    // r0 must ignore this
		emit(enc_i(opc_sw, 5'd0, 5'd0, store_base[15:0] + 16'd24));
		emit(enc_i(opc_beq, 5'd1, 5'd1, 16'd1));     // taken so the next store is skipped
		emit(enc_i(opc_sw, 5'd0, 5'd1, sentinel_addr[15:0]));
		emit(enc_i(opc_addi, 5'd0, 5'd9, marker));
		emit(enc_i(opc_beq, 5'd9, 5'd0, 16'd1));     // not taken
		emit(enc_i(opc_sw, 5'd0, 5'd9, store_base[15:0] + 16'd28));
		done_addr = prog_ptr + 32'd8;
		emit(enc_j(done_addr));
		emit(enc_i(opc_sw, 5'd0, 5'd1, sentinel_addr[15:0])); // jumped over
		emit(enc_j(done_addr));                     // self-loop
	endtask

	// expected store words from the isa rules
	task automatic build_expected();
		for (int i = 0; i < n_stores; i++) exp_addr[i] = store_base + 32'(i * 4);
		exp_data[0] = op_a + op_b;
		exp_data[1] = op_a - op_b;
		exp_data[2] = op_a & op_b;
		exp_data[3] = op_a | op_b;
		exp_data[4] = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
		exp_data[5] = op_a + {{16{neg_imm[15]}}, neg_imm};
		exp_data[6] = 32'd0;
		exp_data[7] = {16'd0, marker};
	endtask

	// every store checked against the next expected one
	always @(negedge clk) begin
		if (rstb && mem_wr_ena) begin
			if (mem_addr == sentinel_addr) begin
				abort_run("store reached the sentinel address, a branch or jump went wrong");
			end else if (store_idx >= n_stores) begin
				abort_run("more stores than the program holds");
			end else begin
				assert (mem_addr == exp_addr[store_idx])
					else value_error("mem_addr", mem_addr, exp_addr[store_idx]);
				assert (mem_wr_data == exp_data[store_idx])
					else value_error("mem_wr_data", mem_wr_data, exp_data[store_idx]);
				store_idx++;
			end
		end
	end

	always @(negedge clk) begin
		if (i_mips.i_mips_props.err_count != 0) abort_run("a timing or fetch assertion failed");
	end

	initial begin
		#((reset_cycles + run_cycles + 40) * 10);
		abort_run("watchdog expired before the core reached the final loop");
	end

	initial begin
		rstb = 1'b0;
		load_image();
		build_expected();
		repeat (reset_cycles) @(posedge clk);
		rstb <= 1'b1;
		@(negedge clk); // still the reset state
		assert (pc == `MIPS_RESET_PC) else value_error("pc", pc, `MIPS_RESET_PC);
		assert (mem_wr_ena == 1'b0) else value_error("mem_wr_ena", {31'd0, mem_wr_ena}, 32'd0);
		assert (mem_addr == `MIPS_RESET_PC) else value_error("mem_addr", mem_addr, `MIPS_RESET_PC);
		while (pc != done_addr) @(negedge clk);
		repeat (3) @(negedge clk); // j lands on itself after one lap
		assert (pc == done_addr) else value_error("pc", pc, done_addr);
		assert (store_idx == n_stores) else abort_run("not every expected store was seen");
		if (i_mips.i_mips_props.err_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run("a timing or fetch assertion failed");
		end
	end

endmodule

// ==== build.f ====
+incdir+common
common/mips_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/control_unit.sv
hw/mips.sv
sim/mips_props.sv
sim/mips_tb.sv
